// ==== logic/barrel_shifter.sv ====
// ----------------------------------------------------------
// Shared barrel shifter. Left shifts reverse the input, pass
// through the right-shifting stages and are read back reversed.
// Purely combinational.
// ----------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module barrel_shifter import shift_pkg::*; (
    input  wire logic [XLEN-1:0] shifter_input,
    input  wire logic [4:0]      shift_amount,
    input  wire logic            arith,
    input  wire logic            lshift,
    output logic      [XLEN-1:0] shifted_resultr,
    output logic      [XLEN-1:0] shifted_resultl
);

    logic [XLEN-1:0] preshifted;
    logic [XLEN-1:0] stage8;
    logic [XLEN-1:0] stage2;
    logic [XLEN-1:0] stage1;

    always_comb begin
        for (int b = 0; b < XLEN; b++)
            preshifted[b] = lshift ? shifter_input[XLEN-1-b] : shifter_input[b]; // mirror for left.
    end

    always_comb begin
        case (shift_amount[4:3])                                // coarse steps of 8.
            2'd0:    stage8 = preshifted;
            2'd1:    stage8 = {{8{arith}}, preshifted[XLEN-1:8]};
            2'd2:    stage8 = {{16{arith}}, preshifted[XLEN-1:16]};
            default: stage8 = {{24{arith}}, preshifted[XLEN-1:24]};
        endcase
    end

    always_comb begin
        case (shift_amount[2:1])                                // steps of 2.
            2'd0:    stage2 = stage8;
            2'd1:    stage2 = {{2{arith}}, stage8[XLEN-1:2]};
            2'd2:    stage2 = {{4{arith}}, stage8[XLEN-1:4]};
            default: stage2 = {{6{arith}}, stage8[XLEN-1:6]};
        endcase
    end

    assign stage1 = shift_amount[0] ? {arith, stage2[XLEN-1:1]} : stage2; // last single step.

    assign shifted_resultr = stage1;

    always_comb begin
        for (int b = 0; b < XLEN; b++)
            shifted_resultl[b] = stage1[XLEN-1-b];              // undo the mirror.
    end

endmodule

`default_nettype wire

// ==== logic/shift_issue.sv ====
// ----------------------------------------------------------
// Issue stage. Accepts an instruction with its operands over
// a four-phase req/ack link, decodes the shift and pushes it
// into the operation buffer before acknowledging.
// ----------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module shift_issue import shift_pkg::*; (
    input  wire logic            clk,
    input  wire logic            arst_n,
    input  wire logic            in_req,
    output logic                 in_ack,
    input  wire instr_word_u     in_instr,
    input  wire logic [XLEN-1:0] in_rs1_value,
    input  wire logic [XLEN-1:0] in_rs2_value,
    shift_op_if.src              op_out
);

    localparam logic [1:0] IDLE    = 2'd0;  // waiting for a request.
    localparam logic [1:0] PUSHING = 2'd1;  // decoded operation offered to the buffer.
    localparam logic [1:0] ACKED   = 2'd2;  // ack high until the request drops.

    logic [1:0] state;
    logic       is_op;                      // high for the register form.
    logic [6:0] upper;
    logic [2:0] funct3;
    logic [4:0] dec_amount;
    logic       dec_lshift;
    logic       dec_arith;
    logic       dec_illegal;

    always_comb begin
        is_op      = in_instr.r.opcode == OPC_OP;
        upper      = in_instr.r.funct7;                            // bits 31..25 of the word.
        funct3     = in_instr.r.funct3;
        dec_amount = is_op ? in_rs2_value[4:0] : in_instr.i.shamt; // rs2 upper bits are ignored.
        dec_lshift = funct3 == F3_SLL;
        dec_arith  = upper[5] && !dec_lshift;                      // bit 30 of the word.
        dec_illegal = 1'b1;                                        // anything unmatched is illegal.
        if (is_op || in_instr.i.opcode == OPC_OP_IMM) begin
            if (funct3 == F3_SLL)
                dec_illegal = upper != 7'b0000000;                 // SLL with bit 30 is rejected.
            else if (funct3 == F3_SRL_SRA)
                dec_illegal = (upper & 7'b1011111) != 7'b0000000;  // only bit 30 may be set.
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state <= IDLE;
        end else begin
            case (state)
                IDLE:    if (in_req) state <= PUSHING;             // operands are stable now.
                PUSHING: if (op_out.ready) state <= ACKED;         // push happens on this edge.
                ACKED:   if (!in_req) state <= IDLE;               // return to zero phase.
                default: state <= IDLE;
            endcase
        end
    end

    // the decoded operation is captured once and held until the buffer takes it.
    always_ff @(posedge clk) begin
        if (state == IDLE && in_req) begin
            op_out.data    <= in_rs1_value;
            op_out.amount  <= dec_amount;
            op_out.arith   <= dec_arith;
            op_out.lshift  <= dec_lshift;
            op_out.rd      <= in_instr.r.rd;                       // rd sits at the same bits in both views.
            op_out.illegal <= dec_illegal;
        end
    end

    assign op_out.valid = state == PUSHING;
    assign in_ack       = state == ACKED;                          // rises the cycle after the push.

    // the ack only ever answers a request that was held on the edge where it rose.
    a_ack_needs_req: assert property (@(posedge clk) disable iff (!arst_n)
        $rose(in_ack) |-> $past(in_req));

endmodule

`default_nettype wire

// ==== logic/shift_op_fifo.sv ====
// ----------------------------------------------------------
// Operation buffer between the issue stage and the shift unit.
// Circular storage of FIFO_DEPTH entries, a power of two of at
// least two. Push and pop may happen on the same edge.
// ----------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module shift_op_fifo import shift_pkg::*; #(
    parameter int FIFO_DEPTH = 4
) (
    input  wire logic clk,
    input  wire logic arst_n,
    shift_op_if.dst   wr,
    shift_op_if.src   rd
);

    localparam int PW = $clog2(FIFO_DEPTH);     // pointer width so the pointers wrap by overflow.
    localparam int CW = PW + 1;                 // count also has to hold a full buffer.
    localparam int EW = XLEN + 13;              // data, amount, rd and three flags.
    localparam logic [CW-1:0] FULL_COUNT = CW'(FIFO_DEPTH);

    logic [EW-1:0] mem [FIFO_DEPTH];
    logic [PW-1:0] wr_ptr;
    logic [PW-1:0] rd_ptr;
    logic [CW-1:0] count;
    logic          push;
    logic          pop;
    logic [EW-1:0] wr_entry;
    logic [EW-1:0] rd_entry;

    assign push = wr.valid && wr.ready;
    assign pop  = rd.valid && rd.ready;

    assign wr_entry = {wr.data, wr.amount, wr.arith, wr.lshift, wr.rd, wr.illegal};

    always_ff @(posedge clk) begin
        if (push)
            mem[wr_ptr] <= wr_entry;            // the offered operation lands at the tail.
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push)
                wr_ptr <= wr_ptr + 1'b1;
            if (pop)
                rd_ptr <= rd_ptr + 1'b1;
            if (push && !pop)
                count <= count + 1'b1;
            else if (pop && !push)
                count <= count - 1'b1;          // simultaneous push and pop keeps the count.
        end
    end

    assign wr.ready = count != FULL_COUNT;      // back-pressure toward the issue stage.
    assign rd.valid = count != '0;              // a pushed entry shows up one edge later.

    assign rd_entry = mem[rd_ptr];
    assign rd.data    = rd_entry[EW-1 -: XLEN];
    assign rd.amount  = rd_entry[12:8];
    assign rd.arith   = rd_entry[7];
    assign rd.lshift  = rd_entry[6];
    assign rd.rd      = rd_entry[5:1];
    assign rd.illegal = rd_entry[0];

    a_count_bound: assert property (@(posedge clk) disable iff (!arst_n)
        count <= FULL_COUNT);

    // an offered entry and its payload stay put until the shift unit takes it.
    a_hold_until_taken: assert property (@(posedge clk) disable iff (!arst_n)
        rd.valid && !rd.ready |=> rd.valid && $stable(rd_entry));

endmodule

`default_nettype wire

// ==== logic/shift_op_if.sv ====
// ----------------------------------------------------------
// One decoded shift operation with a valid/ready pair.
// A transfer takes place on a clock edge where both are high.
// ----------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

interface shift_op_if import shift_pkg::*; ();

    logic            valid;                 // the producer offers an operation.
    logic            ready;                 // the consumer takes it on this edge.
    logic [XLEN-1:0] data;                  // rs1 value to be shifted.
    logic [4:0]      amount;                // shift distance already picked from rs2 or shamt.
    logic            arith;                 // sign fill requested for a right shift.
    logic            lshift;                // shift direction is left.
    logic [4:0]      rd;                    // destination register index.
    logic            illegal;               // the word was not a legal shift.

    modport src (
        output valid, data, amount, arith, lshift, rd, illegal,
        input  ready
    );

    modport dst (
        input  valid, data, amount, arith, lshift, rd, illegal,
        output ready
    );

endinterface

`default_nettype wire

// ==== logic/shift_pkg.sv ====
// ----------------------------------------------------------
// Shared constants and the instruction word type for the
// shift execution unit. Modules import it in their header.
// ----------------------------------------------------------
`default_nettype none

package shift_pkg;

    localparam int XLEN = 32;                      // datapath width, the shifter stages assume 32.

    localparam logic [6:0] OPC_OP     = 7'b0110011; // register-register ALU major opcode.
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011; // register-immediate ALU major opcode.

    localparam logic [2:0] F3_SLL     = 3'b001;     // funct3 of SLL and SLLI.
    localparam logic [2:0] F3_SRL_SRA = 3'b101;     // funct3 shared by the right shifts.

    // the same 32 bits read either as an R-type or as an I-type shift.
    typedef union packed {
        struct packed {
            logic [6:0] funct7;                     // bit 30 of the word is funct7[5].
            logic [4:0] rs2;
            logic [4:0] rs1;
            logic [2:0] funct3;
            logic [4:0] rd;
            logic [6:0] opcode;
        } r;
        struct packed {
            logic [6:0] upper;                      // imm[11:5], holds the SRAI marker bit.
            logic [4:0] shamt;                      // immediate shift amount for RV32.
            logic [4:0] rs1;
            logic [2:0] funct3;
            logic [4:0] rd;
            logic [6:0] opcode;
        } i;
    } instr_word_u;

endpackage

`default_nettype wire

// ==== logic/shift_top.sv ====
// ----------------------------------------------------------
// Top level of the shift execution unit. Chains the issue
// stage, the operation buffer and the shift unit. Both outer
// links use four-phase req/ack.
// ----------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module shift_top import shift_pkg::*; #(
    parameter int FIFO_DEPTH = 4
) (
    input  wire logic            clk,
    input  wire logic            arst_n,
    input  wire logic            in_req,
    output logic                 in_ack,
    input  wire logic [XLEN-1:0] in_instr,
    input  wire logic [XLEN-1:0] in_rs1_value,
    input  wire logic [XLEN-1:0] in_rs2_value,
    output logic                 res_req,
    input  wire logic            res_ack,
    output logic      [XLEN-1:0] res_data,
    output logic      [4:0]      res_rd,
    output logic                 res_illegal
);

    shift_op_if issue_to_buf ();            // decoded operations into the buffer.
    shift_op_if buf_to_unit ();             // buffered operations toward execution.

    shift_issue issue_i (
        .clk          (clk),
        .arst_n       (arst_n),
        .in_req       (in_req),
        .in_ack       (in_ack),
        .in_instr     (in_instr),           // raw word is viewed through the union inside.
        .in_rs1_value (in_rs1_value),
        .in_rs2_value (in_rs2_value),
        .op_out       (issue_to_buf)
    );

    shift_op_fifo #(
        .FIFO_DEPTH (FIFO_DEPTH)
    ) fifo_i (
        .clk    (clk),
        .arst_n (arst_n),
        .wr     (issue_to_buf),
        .rd     (buf_to_unit)
    );

    shift_unit unit_i (
        .clk         (clk),
        .arst_n      (arst_n),
        .op_in       (buf_to_unit),
        .res_req     (res_req),
        .res_ack     (res_ack),
        .res_data    (res_data),
        .res_rd      (res_rd),
        .res_illegal (res_illegal)
    );

endmodule

`default_nettype wire

// ==== logic/shift_unit.sv ====
// ----------------------------------------------------------
// Shift unit. Pops one operation at a time from the buffer,
// shifts it and returns the result with rd and the illegal
// flag over a four-phase req/ack link.
// ----------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module shift_unit import shift_pkg::*; (
    input  wire logic            clk,
    input  wire logic            arst_n,
    shift_op_if.dst              op_in,
    output logic                 res_req,
    input  wire logic            res_ack,
    output logic      [XLEN-1:0] res_data,
    output logic      [4:0]      res_rd,
    output logic                 res_illegal
);

    localparam logic [1:0] IDLE      = 2'd0; // ready for the next operation.
    localparam logic [1:0] WAIT_HIGH = 2'd1; // result offered, waiting for ack.
    localparam logic [1:0] WAIT_LOW  = 2'd2; // req dropped, waiting for ack to clear.

    logic [1:0]      state;
    logic            pop;
    logic            fill;
    logic [XLEN-1:0] shifted_r;
    logic [XLEN-1:0] shifted_l;
    logic [XLEN-1:0] result;

    assign fill = op_in.arith & op_in.data[XLEN-1];     // sign bit only for SRA.

    barrel_shifter shifter_i (
        .shifter_input   (op_in.data),
        .shift_amount    (op_in.amount),
        .arith           (fill),
        .lshift          (op_in.lshift),
        .shifted_resultr (shifted_r),
        .shifted_resultl (shifted_l)
    );

    always_comb begin
        result = op_in.lshift ? shifted_l : shifted_r;
        if (op_in.illegal)
            result = '0;                                 // illegal words return zero data.
    end

    assign op_in.ready = state == IDLE;
    assign pop         = op_in.valid && op_in.ready;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state <= IDLE;
        end else begin
            case (state)
                IDLE:      if (pop) state <= WAIT_HIGH;     // req rises on the next cycle.
                WAIT_HIGH: if (res_ack) state <= WAIT_LOW;
                WAIT_LOW:  if (!res_ack) state <= IDLE;
                default:   state <= IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (pop) begin
            res_data    <= result;
            res_rd      <= op_in.rd;
            res_illegal <= op_in.illegal;
        end
    end

    assign res_req = state == WAIT_HIGH;

    // the environment samples the result any time while req is high.
    a_result_stable: assert property (@(posedge clk) disable iff (!arst_n)
        res_req |=> !res_req || $stable(res_data));

endmodule

`default_nettype wire

// ==== project.f ====
logic/shift_pkg.sv
logic/shift_op_if.sv
logic/barrel_shifter.sv
logic/shift_issue.sv
logic/shift_op_fifo.sv
logic/shift_unit.sv
logic/shift_top.sv
tb/shift_top_tb.sv

// ==== run.sh ====
#!/bin/sh
# Builds the testbench with Verilator and runs it once.
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module shift_top_tb -f project.f

output=$(./obj_dir/Vshift_top_tb)
echo "$output"

# the run counts as passed only if the testbench printed the pass line.
echo "$output" | grep -qx "TESTS PASSED"

// ==== tb/shift_top_tb.sv ====
// ----------------------------------------------------------
// Testbench for the shift execution unit. Feeds instructions
// over the input req/ack link from a table and from an LCG,
// answers the result link and checks results in issue order.
// ----------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module shift_top_tb import shift_pkg::*; ();

    localparam int NUM_ROWS = 15;
    localparam int TIMEOUT  = 2000;              // cycles allowed for any single wait.
    localparam logic [6:0] F7_SRA = 7'b0100000;  // bit 30 marks the arithmetic right shift.

    logic        clk = 1'b0;
    logic        arst_n;
    logic        in_req;
    logic        in_ack;
    logic [31:0] in_instr;
    logic [31:0] in_rs1_value;
    logic [31:0] in_rs2_value;
    logic        res_req;
    logic        res_ack;
    logic [31:0] res_data;
    logic [4:0]  res_rd;
    logic        res_illegal;

    logic [31:0] tab_instr [NUM_ROWS];           // stimulus and expected columns.
    logic [31:0] tab_rs1 [NUM_ROWS];
    logic [31:0] tab_rs2 [NUM_ROWS];
    logic [31:0] tab_data [NUM_ROWS];
    logic [4:0]  tab_rd [NUM_ROWS];
    logic        tab_ill [NUM_ROWS];

    logic [31:0] exp_data_q [$];                 // results still owed by the DUT in issue order.
    logic [4:0]  exp_rd_q [$];
    logic        exp_ill_q [$];

    logic [31:0] rng;
    logic        hung;
    int          error_count;
    int          check_count;
    int          results_expected;
    int          results_seen;
    int          ack_delay;                      // cycles the result link waits before res_ack.
    int          max_ack_wait;

    shift_top #(
        .FIFO_DEPTH (4)
    ) shift_top_i (
        .clk          (clk),
        .arst_n       (arst_n),
        .in_req       (in_req),
        .in_ack       (in_ack),
        .in_instr     (in_instr),
        .in_rs1_value (in_rs1_value),
        .in_rs2_value (in_rs2_value),
        .res_req      (res_req),
        .res_ack      (res_ack),
        .res_data     (res_data),
        .res_rd       (res_rd),
        .res_illegal  (res_illegal)
    );

    always #10 clk = ~clk;                       // 20 ns period.

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    // builds an R-type or I-type word with the rs1 field fixed at x1.
    function automatic logic [31:0] encode(input logic [6:0] f7, input logic [4:0] f5,
                                           input logic [2:0] f3, input logic [4:0] rd,
                                           input logic [6:0] opc);
        return {f7, f5, 5'd1, f3, rd, opc};
    endfunction

    // kind 0 is a logical left shift, 1 a zero filled and 2 a sign filled right shift.
    function automatic logic [31:0] ref_shift(input int kind, input logic [31:0] value,
                                              input logic [4:0] amt);
        case (kind)
            0:       return value << amt;
            1:       return value >> amt;
            default: return 32'($signed(value) >>> amt);
        endcase
    endfunction

    task automatic check_value(input logic [31:0] got, input logic [31:0] exp, input string what);
        check_count++;
        if (got !== exp) begin
            error_count++;
            $display("Mismatch at %0t: %s got %h expected %h", $time, what, got, exp);
        end
    endtask

    task automatic report_hang(input string what);
        $display("Timeout at %0t: %s within %0d cycles", $time, what, TIMEOUT);
        error_count++;
        hung = 1'b1;
        wait (!hung);                            // parks this process while the main block ends the run.
    endtask

    task automatic set_row(input int i, input logic [31:0] instr, input logic [31:0] rs1,
                           input logic [31:0] rs2, input logic [31:0] data,
                           input logic [4:0] rd, input logic ill);
        tab_instr[i] = instr;
        tab_rs1[i]   = rs1;
        tab_rs2[i]   = rs2;
        tab_data[i]  = data;
        tab_rd[i]    = rd;
        tab_ill[i]   = ill;
    endtask

    task automatic load_table();
        // register forms with upper rs2 bits set on rows 1 and 4.
        set_row(0, encode(7'h00, 5'd2, F3_SLL, 5'd1, OPC_OP), 32'h1, 32'd31, 32'h8000_0000,
                5'd1, 1'b0);
        set_row(1, encode(7'h00, 5'd3, F3_SLL, 5'd2, OPC_OP), 32'h1234_5678, 32'hffff_ff04,
                32'h2345_6780, 5'd2, 1'b0);
        set_row(2, encode(7'h00, 5'd4, F3_SRL_SRA, 5'd3, OPC_OP), 32'h8000_0000, 32'd31, 32'h1,
                5'd3, 1'b0);
        set_row(3, encode(7'h00, 5'd5, F3_SRL_SRA, 5'd4, OPC_OP), 32'hf000_000f, 32'd0,
                32'hf000_000f, 5'd4, 1'b0);
        set_row(4, encode(F7_SRA, 5'd6, F3_SRL_SRA, 5'd5, OPC_OP), 32'h8000_0000, 32'hffff_ffff,
                32'hffff_ffff, 5'd5, 1'b0);
        set_row(5, encode(F7_SRA, 5'd7, F3_SRL_SRA, 5'd6, OPC_OP), 32'hf0f0_0000, 32'd4,
                32'hff0f_0000, 5'd6, 1'b0);
        set_row(6, encode(F7_SRA, 5'd8, F3_SRL_SRA, 5'd7, OPC_OP), 32'h7000_0000, 32'd28, 32'h7,
                5'd7, 1'b0);
        // in the immediate forms rs2 carries junk that must not matter.
        set_row(7, encode(7'h00, 5'd8, F3_SLL, 5'd8, OPC_OP_IMM), 32'hff, 32'hdead_beef, 32'hff00,
                5'd8, 1'b0);
        set_row(8, encode(7'h00, 5'd16, F3_SRL_SRA, 5'd9, OPC_OP_IMM), 32'h8765_4321, 32'd0,
                32'h8765, 5'd9, 1'b0);
        set_row(9, encode(F7_SRA, 5'd16, F3_SRL_SRA, 5'd10, OPC_OP_IMM), 32'h8765_4321, 32'd0,
                32'hffff_8765, 5'd10, 1'b0);
        set_row(10, encode(F7_SRA, 5'd0, F3_SRL_SRA, 5'd31, OPC_OP_IMM), 32'h8000_0001, 32'h1f,
                32'h8000_0001, 5'd31, 1'b0);
        // LUI, ADD, SLL with bit 30 and SLTI are all rejected with zero data.
        set_row(11, encode(7'h00, 5'd0, 3'b000, 5'd12, 7'b0110111), 32'hffff_ffff, 32'd1, 32'd0,
                5'd12, 1'b1);
        set_row(12, encode(7'h00, 5'd2, 3'b000, 5'd13, OPC_OP), 32'hffff_ffff, 32'd1, 32'd0,
                5'd13, 1'b1);
        set_row(13, encode(F7_SRA, 5'd2, F3_SLL, 5'd14, OPC_OP), 32'hffff_ffff, 32'd1, 32'd0,
                5'd14, 1'b1);
        set_row(14, encode(7'h00, 5'd3, 3'b010, 5'd15, OPC_OP_IMM), 32'hffff_ffff, 32'd1, 32'd0,
                5'd15, 1'b1);
    endtask

    // one four-phase transfer on the input link.
    task automatic send_op(input logic [31:0] instr, input logic [31:0] rs1,
                           input logic [31:0] rs2);
        int cycles;
        @(negedge clk);
        in_instr     = instr;
        in_rs1_value = rs1;
        in_rs2_value = rs2;
        in_req       = 1'b1;
        cycles       = 0;
        while (!in_ack) begin
            @(negedge clk);
            cycles++;
            if (cycles > TIMEOUT)
                report_hang("in_ack did not rise");
        end
        if (cycles > max_ack_wait)
            max_ack_wait = cycles;
        in_req = 1'b0;
        cycles = 0;
        while (in_ack) begin
            @(negedge clk);
            cycles++;
            if (cycles > TIMEOUT)
                report_hang("in_ack did not fall after in_req dropped");
        end
    endtask

    task automatic issue_op(input logic [31:0] instr, input logic [31:0] rs1,
                            input logic [31:0] rs2, input logic [31:0] data,
                            input logic [4:0] rd, input logic ill);
        exp_data_q.push_back(data);              // queued first, the result may come back fast.
        exp_rd_q.push_back(rd);
        exp_ill_q.push_back(ill);
        results_expected++;
        send_op(instr, rs1, rs2);
    endtask

    task automatic issue_row(input int i);
        issue_op(tab_instr[i], tab_rs1[i], tab_rs2[i], tab_data[i], tab_rd[i], tab_ill[i]);
    endtask

    task automatic issue_random();
        int          kind;
        logic        imm_form;
        logic [31:0] rs1;
        logic [31:0] rs2;
        logic [4:0]  shamt;
        logic [4:0]  rd;
        logic [4:0]  amount;
        rng = lcg_next(rng);
        kind = int'(rng[31:16]) % 3;
        imm_form = rng[27];
        rng = lcg_next(rng);
        rs1 = rng;
        rng = lcg_next(rng);
        rs2 = rng;
        rng = lcg_next(rng);
        shamt = rng[24:20];                      // doubles as the rs2 index in the register form.
        rd = rng[12:8];
        amount = imm_form ? shamt : rs2[4:0];
        issue_op(encode(kind == 2 ? F7_SRA : 7'h00, shamt, kind == 0 ? F3_SLL : F3_SRL_SRA, rd,
                        imm_form ? OPC_OP_IMM : OPC_OP),
                 rs1, rs2, ref_shift(kind, rs1, amount), rd, 1'b0);
    endtask

    // answers the result link and checks each result against the oldest expectation.
    task automatic collect_results();
        int          cycles;
        logic [31:0] exp_data;
        logic [4:0]  exp_rd;
        logic        exp_ill;
        forever begin
            cycles = 0;
            while (!res_req) begin
                @(negedge clk);
                cycles++;
                if (cycles > TIMEOUT)
                    report_hang("res_req did not rise");
            end
            if (exp_data_q.size() == 0) begin
                error_count++;
                $display("Result at %0t arrived with no request pending", $time);
            end else begin
                exp_data = exp_data_q.pop_front();
                exp_rd   = exp_rd_q.pop_front();
                exp_ill  = exp_ill_q.pop_front();
                check_value(res_data, exp_data, $sformatf("data of result %0d", results_seen));
                check_value(32'(res_rd), 32'(exp_rd), $sformatf("rd of result %0d", results_seen));
                check_value(32'(res_illegal), 32'(exp_ill),
                            $sformatf("illegal of result %0d", results_seen));
            end
            results_seen++;
            repeat (ack_delay) @(negedge clk);
            res_ack = 1'b1;
            cycles = 0;
            while (res_req) begin
                @(negedge clk);
                cycles++;
                if (cycles > TIMEOUT)
                    report_hang("res_req did not fall after res_ack");
            end
            res_ack = 1'b0;
        end
    endtask

    task automatic wait_drain();
        int cycles;
        cycles = 0;
        while (results_seen != results_expected || res_req || res_ack) begin
            @(negedge clk);
            cycles++;
            if (cycles > TIMEOUT)
                report_hang("outstanding results did not drain");
        end
    endtask

    task automatic end_test(input string name, input int errs_before);
        $display("test %-14s %s", name, error_count == errs_before ? "ok" : "failed");
    endtask

    task automatic run_tests();
        int errs;
        errs = error_count;
        check_value(32'(in_ack), 32'd0, "in_ack after reset");
        check_value(32'(res_req), 32'd0, "res_req after reset");
        end_test("reset", errs);
        errs = error_count;
        for (int r = 0; r < 7; r++)
            issue_row(r);
        wait_drain();
        end_test("register", errs);
        errs = error_count;
        for (int r = 7; r < 11; r++)
            issue_row(r);
        wait_drain();
        end_test("immediate", errs);
        errs = error_count;
        for (int r = 11; r < NUM_ROWS; r++)
            issue_row(r);
        wait_drain();
        end_test("illegal", errs);
        errs = error_count;
        ack_delay = 30;                          // slow result link fills the buffer.
        max_ack_wait = 0;
        for (int r = 0; r < NUM_ROWS; r++)
            issue_row(r);
        wait_drain();
        check_value(32'(max_ack_wait > 20), 32'd1, "in_ack stall while the buffer was full");
        ack_delay = 0;
        end_test("back-pressure", errs);
        errs = error_count;
        for (int n = 0; n < 50; n++)
            issue_random();
        wait_drain();
        end_test("random", errs);
    endtask

    initial begin
        arst_n = 1'b0;
        in_req = 1'b0;
        in_instr = '0;
        in_rs1_value = '0;
        in_rs2_value = '0;
        res_ack = 1'b0;
        rng = 32'h7e1081e1;
        hung = 1'b0;
        error_count = 0;
        check_count = 0;
        results_expected = 0;
        results_seen = 0;
        ack_delay = 0;
        max_ack_wait = 0;
        load_table();
        repeat (10) @(negedge clk);
        arst_n = 1'b1;
        fork
            run_tests();
            collect_results();
            wait (hung);
        join_any
        $display("checks %0d, errors %0d", check_count, error_count);
        if (error_count == 0)
            $display("TESTS PASSED");
        else
            $display("TESTS FAILED");
        $finish;
    end

endmodule

`default_nettype wire
